/* hdl/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Widths
`define CSR_NUM_W       14
`define CSR_DATA_W      32
`define CSR_INT_W       13

// CSR addresses
`define CSR_CRMD        14'h0000
`define CSR_PRMD        14'h0001
`define CSR_ECFG        14'h0004
`define CSR_ESTAT       14'h0005
`define CSR_ERA         14'h0006
`define CSR_EENTRY      14'h000c
`define CSR_SAVE0       14'h0030
`define CSR_SAVE1       14'h0031
`define CSR_SAVE2       14'h0032
`define CSR_SAVE3       14'h0033
`define CSR_TCFG        14'h0041
`define CSR_TVAL        14'h0042
`define CSR_TICLR       14'h0044

// Field positions
`define CSR_CRMD_PLV    1:0
`define CSR_CRMD_IE     2
`define CSR_CRMD_DA     3
`define CSR_CRMD_PG     4
`define CSR_PRMD_PPLV   1:0
`define CSR_PRMD_PIE    2
`define CSR_ECFG_LIE    12:0
`define CSR_ESTAT_IS10  1:0
`define CSR_ESTAT_IS    12:0
`define CSR_ESTAT_ECODE 21:16
`define CSR_ESTAT_ESUB  30:22
`define CSR_EENTRY_VA   31:6
`define CSR_TCFG_EN     0
`define CSR_TCFG_PERIODIC 1
`define CSR_TCFG_INITVAL  31:2
`define CSR_TICLR_CLR   0
`define CSR_IS_TIMER    11

// Exception codes
`define ECODE_INT       6'h00
`define ECODE_ADE       6'h08
`define ECODE_ALE       6'h09
`define ECODE_SYS       6'h0b
`define ECODE_BRK       6'h0c
`define ECODE_INE       6'h0d

// Reset values
`define CSR_CRMD_RESET  32'h0000_0008
`define CSR_TIMER_IDLE  32'hffff_ffff

`endif

/* hdl/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

  // Register address and data
  typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
  typedef logic [`CSR_DATA_W-1:0] csr_data_t;

  // Exception fields
  typedef logic [5:0] ecode_t;
  typedef logic [8:0] esubcode_t;
  typedef logic [1:0] plv_t;

  // Interrupt status and enable
  typedef logic [`CSR_INT_W-1:0] int_vec_t;

  // One write from the pipeline, 79 bits
  typedef struct packed {
    logic      we;
    csr_num_t  num;
    csr_data_t mask;
    csr_data_t value;
  } csr_wr_t;

  // Writeback stage event, 49 bits
  typedef struct packed {
    logic      ex;
    logic      eret;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_data_t pc;
  } exc_evt_t;

  // Masked write merge
  function automatic csr_data_t wr_merge(
    input csr_data_t mask,
    input csr_data_t value,
    input csr_data_t old
  );
    return (mask & value) | (~mask & old);
  endfunction

endpackage

/* hdl/csr_exc_regs.sv */
`include "csr_params.svh"

module csr_exc_regs (
  input  logic                clk,
  input  logic                reset,
  input  csr_pkg::csr_wr_t    wr,
  input  csr_pkg::exc_evt_t   evt,
  input  csr_pkg::csr_num_t   rd_num,
  input  csr_pkg::int_vec_t   is_vec,
  output csr_pkg::csr_data_t  rd_data,
  output logic                crmd_ie,
  output csr_pkg::csr_data_t  crmd_value
);

  localparam csr_pkg::csr_data_t CRMD_RST = `CSR_CRMD_RESET;

  csr_pkg::plv_t      crmd_plv;
  logic               crmd_da;
  logic               crmd_pg;
  csr_pkg::plv_t      prmd_pplv;
  logic               prmd_pie;
  csr_pkg::ecode_t    estat_ecode;
  csr_pkg::esubcode_t estat_esub;
  csr_pkg::csr_data_t era_pc;
  logic [31:6]        eentry_va;

  csr_pkg::csr_data_t prmd_word;
  csr_pkg::csr_data_t estat_word;
  csr_pkg::csr_data_t eentry_word;
  csr_pkg::csr_data_t crmd_next;
  csr_pkg::csr_data_t prmd_next;
  csr_pkg::csr_data_t era_next;
  csr_pkg::csr_data_t eentry_next;

  logic wr_crmd;
  logic wr_prmd;
  logic wr_era;
  logic wr_eentry;

  assign wr_crmd   = wr.we && (wr.num == `CSR_CRMD);
  assign wr_prmd   = wr.we && (wr.num == `CSR_PRMD);
  assign wr_era    = wr.we && (wr.num == `CSR_ERA);
  assign wr_eentry = wr.we && (wr.num == `CSR_EENTRY);

  // Register words as software sees them
  always_comb begin
    crmd_value = '0;
    crmd_value[`CSR_CRMD_PLV] = crmd_plv;
    crmd_value[`CSR_CRMD_IE]  = crmd_ie;
    crmd_value[`CSR_CRMD_DA]  = crmd_da;
    crmd_value[`CSR_CRMD_PG]  = crmd_pg;

    prmd_word = '0;
    prmd_word[`CSR_PRMD_PPLV] = prmd_pplv;
    prmd_word[`CSR_PRMD_PIE]  = prmd_pie;

    estat_word = '0;
    estat_word[`CSR_ESTAT_IS]    = is_vec;
    estat_word[`CSR_ESTAT_ECODE] = estat_ecode;
    estat_word[`CSR_ESTAT_ESUB]  = estat_esub;

    eentry_word = '0;
    eentry_word[`CSR_EENTRY_VA] = eentry_va;
  end

  assign crmd_next   = csr_pkg::wr_merge(wr.mask, wr.value, crmd_value);
  assign prmd_next   = csr_pkg::wr_merge(wr.mask, wr.value, prmd_word);
  assign era_next    = csr_pkg::wr_merge(wr.mask, wr.value, era_pc);
  assign eentry_next = csr_pkg::wr_merge(wr.mask, wr.value, eentry_word);

  // CRMD, exception entry drops to kernel with interrupts off
  always_ff @(posedge clk) begin
    if (reset) begin
      crmd_plv <= CRMD_RST[`CSR_CRMD_PLV];
      crmd_ie  <= CRMD_RST[`CSR_CRMD_IE];
      crmd_da  <= CRMD_RST[`CSR_CRMD_DA];
      crmd_pg  <= CRMD_RST[`CSR_CRMD_PG];
    end else if (evt.ex) begin
      crmd_plv <= '0;
      crmd_ie  <= 1'b0;
    end else if (evt.eret) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else if (wr_crmd) begin
      crmd_plv <= crmd_next[`CSR_CRMD_PLV];
      crmd_ie  <= crmd_next[`CSR_CRMD_IE];
      crmd_da  <= crmd_next[`CSR_CRMD_DA];
      crmd_pg  <= crmd_next[`CSR_CRMD_PG];
    end
  end

  // PRMD keeps the interrupted context
  always_ff @(posedge clk) begin
    if (evt.ex) begin
      prmd_pplv <= crmd_plv;
      prmd_pie  <= crmd_ie;
    end else if (wr_prmd) begin
      prmd_pplv <= prmd_next[`CSR_PRMD_PPLV];
      prmd_pie  <= prmd_next[`CSR_PRMD_PIE];
    end
  end

  always_ff @(posedge clk) begin
    if (evt.ex) begin
      estat_ecode <= evt.ecode;
      estat_esub  <= evt.esubcode;
    end
  end

  always_ff @(posedge clk) begin
    if (evt.ex) begin
      era_pc <= evt.pc;
    end else if (wr_era) begin
      era_pc <= era_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_eentry) begin
      eentry_va <= eentry_next[`CSR_EENTRY_VA];
    end
  end

  always_comb begin
    case (rd_num)
      `CSR_CRMD:   rd_data = crmd_value;
      `CSR_PRMD:   rd_data = prmd_word;
      `CSR_ESTAT:  rd_data = estat_word;
      `CSR_ERA:    rd_data = era_pc;
      `CSR_EENTRY: rd_data = eentry_word;
      default:     rd_data = '0;
    endcase
  end

endmodule

/* hdl/csr_int_ctrl.sv */
`include "csr_params.svh"

module csr_int_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::csr_num_t  rd_num,
  input  logic [7:0]         hw_int,
  input  logic               crmd_ie,
  input  logic               timer_zero,
  output csr_pkg::int_vec_t  is_vec,
  output csr_pkg::csr_data_t rd_data,
  output logic               has_int
);

  csr_pkg::int_vec_t  ecfg_lie;
  logic [1:0]         is_sw;
  logic [7:0]         is_hw;
  logic               is_timer;

  csr_pkg::csr_data_t ecfg_word;
  csr_pkg::csr_data_t ecfg_next;
  csr_pkg::csr_data_t estat_next;

  logic wr_ecfg;
  logic wr_estat;
  logic ticlr_clr;

  assign wr_ecfg   = wr.we && (wr.num == `CSR_ECFG);
  assign wr_estat  = wr.we && (wr.num == `CSR_ESTAT);
  assign ticlr_clr = wr.we && (wr.num == `CSR_TICLR)
                     && wr.mask[`CSR_TICLR_CLR] && wr.value[`CSR_TICLR_CLR];

  // IS[12] and IS[10] are not implemented
  always_comb begin
    is_vec = '0;
    is_vec[`CSR_ESTAT_IS10]  = is_sw;
    is_vec[9:2]              = is_hw;
    is_vec[`CSR_IS_TIMER]    = is_timer;

    ecfg_word = '0;
    ecfg_word[`CSR_ECFG_LIE] = ecfg_lie;
  end

  assign ecfg_next  = csr_pkg::wr_merge(wr.mask, wr.value, ecfg_word);
  assign estat_next = csr_pkg::wr_merge(wr.mask, wr.value, {19'b0, is_vec});

  always_ff @(posedge clk) begin
    if (reset) begin
      ecfg_lie <= '0;
    end else if (wr_ecfg) begin
      ecfg_lie <= ecfg_next[`CSR_ECFG_LIE];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      is_sw    <= '0;
      is_hw    <= '0;
      is_timer <= 1'b0;
    end else begin
      if (wr_estat) begin
        is_sw <= estat_next[`CSR_ESTAT_IS10];
      end
      // Hardware lines sampled with one cycle of delay
      is_hw <= hw_int;
      if (timer_zero) begin
        is_timer <= 1'b1;
      end else if (ticlr_clr) begin
        is_timer <= 1'b0;
      end
    end
  end

  assign has_int = (|(is_vec[11:0] & ecfg_lie[11:0])) && crmd_ie;

  // TICLR is write-only and falls to the default
  always_comb begin
    case (rd_num)
      `CSR_ECFG: rd_data = ecfg_word;
      default:   rd_data = '0;
    endcase
  end

endmodule

/* hdl/csr_timer.sv */
`include "csr_params.svh"

module csr_timer (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::csr_num_t  rd_num,
  output logic               timer_zero,
  output csr_pkg::csr_data_t rd_data
);

  localparam csr_pkg::csr_data_t IDLE = `CSR_TIMER_IDLE;

  logic               tcfg_en;
  logic               tcfg_periodic;
  logic [31:2]        tcfg_initval;
  csr_pkg::csr_data_t cnt;

  csr_pkg::csr_data_t tcfg_word;
  csr_pkg::csr_data_t tcfg_next;
  logic               wr_tcfg;
  logic               cnt_run;

  assign wr_tcfg = wr.we && (wr.num == `CSR_TCFG);

  always_comb begin
    tcfg_word = '0;
    tcfg_word[`CSR_TCFG_EN]       = tcfg_en;
    tcfg_word[`CSR_TCFG_PERIODIC] = tcfg_periodic;
    tcfg_word[`CSR_TCFG_INITVAL]  = tcfg_initval;
  end

  // Load value comes from the merged word, not the old TCFG
  assign tcfg_next = csr_pkg::wr_merge(wr.mask, wr.value, tcfg_word);

  always_ff @(posedge clk) begin
    if (reset) begin
      tcfg_en <= 1'b0;
    end else if (wr_tcfg) begin
      tcfg_en <= tcfg_next[`CSR_TCFG_EN];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_tcfg) begin
      tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIODIC];
      tcfg_initval  <= tcfg_next[`CSR_TCFG_INITVAL];
    end
  end

  assign cnt_run = tcfg_en && (cnt != IDLE);

  // Down-counter, stops at the idle value in one-shot mode
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= IDLE;
    end else if (wr_tcfg && tcfg_next[`CSR_TCFG_EN]) begin
      cnt <= {tcfg_next[`CSR_TCFG_INITVAL], 2'b00};
    end else if (cnt_run) begin
      if (cnt == '0 && tcfg_periodic) begin
        cnt <= {tcfg_initval, 2'b00};
      end else begin
        // From zero this wraps to the idle value
        cnt <= cnt - 32'd1;
      end
    end
  end

  assign timer_zero = tcfg_en && (cnt == '0);

  always_comb begin
    case (rd_num)
      `CSR_TCFG: rd_data = tcfg_word;
      `CSR_TVAL: rd_data = cnt;
      default:   rd_data = '0;
    endcase
  end

endmodule

/* hdl/csr_save_regs.sv */
`include "csr_params.svh"

module csr_save_regs (
  input  logic               clk,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::csr_num_t  rd_num,
  output csr_pkg::csr_data_t rd_data
);

  localparam int NUM_SAVE = 4;
  localparam csr_pkg::csr_num_t SAVE_NUM [NUM_SAVE] = '{
    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3
  };

  csr_pkg::csr_data_t save_q [NUM_SAVE];

  // Scratch space for the exception handler
  for (genvar i = 0; i < NUM_SAVE; i++) begin : g_save
    always_ff @(posedge clk) begin
      if (wr.we && (wr.num == SAVE_NUM[i])) begin
        save_q[i] <= csr_pkg::wr_merge(wr.mask, wr.value, save_q[i]);
      end
    end
  end

  always_comb begin
    rd_data = '0;
    for (int i = 0; i < NUM_SAVE; i++) begin
      if (rd_num == SAVE_NUM[i]) begin
        rd_data = save_q[i];
      end
    end
  end

endmodule

/* hdl/csr_file.sv */
`include "csr_params.svh"

module csr_file (
  input  logic               clk,
  input  logic               reset,
  input  csr_pkg::csr_wr_t   wr,
  input  csr_pkg::csr_num_t  rd_num,
  input  csr_pkg::exc_evt_t  evt,
  input  logic [7:0]         hw_int,
  output csr_pkg::csr_data_t rd_data,
  output logic               has_int,
  output csr_pkg::csr_data_t crmd_value
);

  csr_pkg::csr_data_t exc_rd;
  csr_pkg::csr_data_t int_rd;
  csr_pkg::csr_data_t timer_rd;
  csr_pkg::csr_data_t save_rd;

  csr_pkg::int_vec_t  is_vec;
  logic               crmd_ie;
  logic               timer_zero;

  csr_exc_regs u_exc_regs (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .evt        (evt),
    .rd_num     (rd_num),
    .is_vec     (is_vec),
    .rd_data    (exc_rd),
    .crmd_ie    (crmd_ie),
    .crmd_value (crmd_value)
  );

  csr_int_ctrl u_int_ctrl (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .rd_num     (rd_num),
    .hw_int     (hw_int),
    .crmd_ie    (crmd_ie),
    .timer_zero (timer_zero),
    .is_vec     (is_vec),
    .rd_data    (int_rd),
    .has_int    (has_int)
  );

  csr_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .rd_num     (rd_num),
    .timer_zero (timer_zero),
    .rd_data    (timer_rd)
  );

  csr_save_regs u_save_regs (
    .clk     (clk),
    .wr      (wr),
    .rd_num  (rd_num),
    .rd_data (save_rd)
  );

  // Groups decode disjoint addresses, so OR is enough
  assign rd_data = exc_rd | int_rd | timer_rd | save_rd;

endmodule

/* sim/csr_file_tb.sv */
`include "csr_params.svh"

module csr_file_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_INITVAL  = 10;
  // Four timer intervals and roughly 150 cycles of register and interrupt steps
  localparam int TEST_CYCLES  = 4 * (4 * MAX_INITVAL + 4) + 150;
  localparam int MARGIN       = 100;
  localparam logic [31:0] LFSR_SEED = 32'hcd72d4ea;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int NUM_RW = 7;

  localparam csr_pkg::csr_num_t RW_NUM [NUM_RW] = '{
    `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY, `CSR_CRMD
  };
  // Writable bits of the registers above
  localparam csr_pkg::csr_data_t RW_BITS [NUM_RW] = '{
    32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
    32'hffff_ffff, 32'hffff_ffc0, 32'h0000_001f
  };

  logic               clk;
  logic               reset;
  csr_pkg::csr_wr_t   wr;
  csr_pkg::csr_num_t  rd_num;
  csr_pkg::exc_evt_t  evt;
  logic [7:0]         hw_int;
  csr_pkg::csr_data_t rd_data;
  logic               has_int;
  csr_pkg::csr_data_t crmd_value;
  logic [31:0]        lfsr_state;

  csr_file uut (
    .clk        (clk),
    .reset      (reset),
    .wr         (wr),
    .rd_num     (rd_num),
    .evt        (evt),
    .hw_int     (hw_int),
    .rd_data    (rd_data),
    .has_int    (has_int),
    .crmd_value (crmd_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input csr_pkg::csr_data_t got,
                          input csr_pkg::csr_data_t exp);
    assert (got === exp) else
      stop_on_error($sformatf("FAIL @ %0t: %s: got 0x%08h, expected 0x%08h",
                              $time, what, got, exp));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output csr_pkg::csr_data_t bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Write is driven on a falling edge and lands on the next rising edge
  task automatic write_csr(input csr_pkg::csr_num_t num, input csr_pkg::csr_data_t mask,
                           input csr_pkg::csr_data_t value);
    @(negedge clk);
    wr.we    = 1'b1;
    wr.num   = num;
    wr.mask  = mask;
    wr.value = value;
    @(negedge clk);
    wr.we = 1'b0;
  endtask

  task automatic read_csr(input csr_pkg::csr_num_t num, output csr_pkg::csr_data_t data);
    rd_num = num;
    #1;
    data = rd_data;
  endtask

  task automatic expect_timer_bit(input string what, input logic exp);
    csr_pkg::csr_data_t got;
    read_csr(`CSR_ESTAT, got);
    check_eq(what, {31'b0, got[`CSR_IS_TIMER]}, {31'b0, exp});
  endtask

  task automatic expect_int(input string what, input logic exp);
    #1;
    check_eq(what, {31'b0, has_int}, {31'b0, exp});
  endtask

  task automatic test_reset_values;
    csr_pkg::csr_data_t got;
    read_csr(`CSR_CRMD, got);
    check_eq("CRMD after reset", got, 32'h0000_0008);
    check_eq("crmd_value after reset", crmd_value, 32'h0000_0008);
    read_csr(`CSR_ECFG, got);
    check_eq("ECFG after reset", got, 32'h0);
    @(negedge clk);
    read_csr(`CSR_ESTAT, got);
    check_eq("ESTAT.IS after reset", got & 32'h1fff, 32'h0);
    read_csr(`CSR_TVAL, got);
    check_eq("TVAL after reset", got, 32'hffff_ffff);
    check_eq("has_int after reset", {31'b0, has_int}, 32'h0);
  endtask

  task automatic test_masked_writes;
    csr_pkg::csr_data_t model;
    csr_pkg::csr_data_t value;
    csr_pkg::csr_data_t mask;
    csr_pkg::csr_data_t got;
    for (int r = 0; r < NUM_RW; r++) begin
      write_csr(RW_NUM[r], 32'hffff_ffff, 32'h0);
      model = '0;
      for (int k = 0; k < 4; k++) begin
        random_bits(32, value);
        random_bits(32, mask);
        write_csr(RW_NUM[r], mask, value);
        model = ((mask & value) | (~mask & model)) & RW_BITS[r];
        read_csr(RW_NUM[r], got);
        check_eq($sformatf("masked write to CSR 0x%03h", RW_NUM[r]), got, model);
      end
    end
    read_csr(14'h0002, got);
    check_eq("unknown CSR 0x002", got, 32'h0);
    read_csr(14'h3fff, got);
    check_eq("unknown CSR 0x3fff", got, 32'h0);
    read_csr(`CSR_TICLR, got);
    check_eq("TICLR read", got, 32'h0);
  endtask

  task automatic test_exception_entry;
    csr_pkg::csr_data_t old_crmd;
    csr_pkg::csr_data_t bits;
    csr_pkg::csr_data_t pc;
    csr_pkg::csr_data_t got;
    csr_pkg::ecode_t    ecode;
    csr_pkg::esubcode_t esub;
    write_csr(`CSR_CRMD, 32'h7, 32'h7);
    read_csr(`CSR_CRMD, old_crmd);
    check_eq("CRMD PLV and IE before exception", old_crmd & 32'h7, 32'h7);
    random_bits(6, bits);
    ecode = bits[5:0];
    random_bits(9, bits);
    esub = bits[8:0];
    random_bits(32, pc);
    @(negedge clk);
    evt.ex       = 1'b1;
    evt.ecode    = ecode;
    evt.esubcode = esub;
    evt.pc       = pc;
    // Competing CRMD write in the same cycle
    wr.we    = 1'b1;
    wr.num   = `CSR_CRMD;
    wr.mask  = 32'hffff_ffff;
    wr.value = ~old_crmd;
    @(negedge clk);
    evt   = '0;
    wr.we = 1'b0;
    read_csr(`CSR_CRMD, got);
    check_eq("CRMD after exception", got, old_crmd & 32'h18);
    check_eq("crmd_value after exception", crmd_value, old_crmd & 32'h18);
    read_csr(`CSR_PRMD, got);
    check_eq("PRMD after exception", got, 32'h7);
    @(negedge clk);
    read_csr(`CSR_ESTAT, got);
    check_eq("ESTAT codes after exception", got & 32'h7fff_0000, {1'b0, esub, ecode, 16'h0});
    read_csr(`CSR_ERA, got);
    check_eq("ERA after exception", got, pc);
  endtask

  task automatic test_exception_return;
    csr_pkg::csr_data_t old_crmd;
    csr_pkg::csr_data_t pplv;
    csr_pkg::csr_data_t got;
    random_bits(2, pplv);
    write_csr(`CSR_PRMD, 32'h7, pplv | 32'h4);
    read_csr(`CSR_CRMD, old_crmd);
    @(negedge clk);
    evt.eret = 1'b1;
    @(negedge clk);
    evt = '0;
    read_csr(`CSR_CRMD, got);
    check_eq("CRMD after return", got, (old_crmd & 32'h18) | pplv | 32'h4);
    read_csr(`CSR_PRMD, got);
    check_eq("PRMD after return", got, pplv | 32'h4);
  endtask

  task automatic test_timer;
    csr_pkg::csr_data_t bits;
    csr_pkg::csr_data_t got;
    int n;
    random_bits(3, bits);
    n = int'(bits) + 3;
    write_csr(`CSR_TCFG, 32'hffff_ffff, (csr_pkg::csr_data_t'(n) << 2) | 32'h1);
    for (int e = 0; e <= 4 * n; e++) begin
      read_csr(`CSR_TVAL, got);
      check_eq("one-shot TVAL", got, csr_pkg::csr_data_t'(4 * n - e));
      expect_timer_bit("IS[11] before one-shot expiry", 1'b0);
      @(negedge clk);
    end
    expect_timer_bit("IS[11] at one-shot expiry", 1'b1);
    read_csr(`CSR_TVAL, got);
    check_eq("TVAL after one-shot expiry", got, 32'hffff_ffff);
    @(negedge clk);
    read_csr(`CSR_TVAL, got);
    check_eq("TVAL stays idle", got, 32'hffff_ffff);
    write_csr(`CSR_TICLR, 32'h1, 32'h1);
    expect_timer_bit("IS[11] after TICLR", 1'b0);

    // Periodic mode
    write_csr(`CSR_TCFG, 32'hffff_ffff, (csr_pkg::csr_data_t'(n) << 2) | 32'h3);
    for (int e = 0; e <= 4 * n; e++) begin
      expect_timer_bit("IS[11] before first periodic expiry", 1'b0);
      @(negedge clk);
    end
    expect_timer_bit("IS[11] at first periodic expiry", 1'b1);
    read_csr(`CSR_TVAL, got);
    check_eq("TVAL after periodic reload", got, csr_pkg::csr_data_t'(4 * n));
    // TICLR lands on edge 4n+3 after the load
    write_csr(`CSR_TICLR, 32'h1, 32'h1);
    for (int e = 4 * n + 3; e <= 8 * n + 1; e++) begin
      expect_timer_bit("IS[11] before second periodic expiry", 1'b0);
      @(negedge clk);
    end
    expect_timer_bit("IS[11] at second periodic expiry", 1'b1);
    write_csr(`CSR_TCFG, 32'hffff_ffff, 32'h0);
    write_csr(`CSR_TICLR, 32'h1, 32'h1);
    expect_timer_bit("IS[11] with timer off", 1'b0);
  endtask

  task automatic test_interrupts;
    csr_pkg::csr_data_t bits;
    int                 line;
    int                 n;
    // IE was restored to 1 by the return test
    write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0000_0001);
    expect_int("LIE set with IS clear", 1'b0);
    write_csr(`CSR_ESTAT, 32'h3, 32'h1);
    expect_int("software bit 0", 1'b1);
    write_csr(`CSR_CRMD, 32'h4, 32'h0);
    expect_int("IE cleared", 1'b0);
    write_csr(`CSR_CRMD, 32'h4, 32'h4);
    expect_int("IE set again", 1'b1);
    write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0);
    expect_int("LIE cleared", 1'b0);
    write_csr(`CSR_ESTAT, 32'h3, 32'h0);

    random_bits(3, bits);
    line = int'(bits);
    write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0000_0004 << line);
    hw_int = 8'h01 << line;
    expect_int("hw_int before sampling", 1'b0);
    @(negedge clk);
    expect_int("hw_int sampled", 1'b1);
    @(negedge clk);
    hw_int = 8'h00;
    expect_int("hw_int released before sampling", 1'b1);
    @(negedge clk);
    expect_int("hw_int released", 1'b0);

    write_csr(`CSR_ECFG, 32'hffff_ffff, 32'h0000_0800);
    random_bits(3, bits);
    n = int'(bits) + 3;
    write_csr(`CSR_TCFG, 32'hffff_ffff, (csr_pkg::csr_data_t'(n) << 2) | 32'h1);
    for (int e = 0; e <= 4 * n; e++) begin
      expect_int("timer interrupt before expiry", 1'b0);
      @(negedge clk);
    end
    expect_int("timer interrupt at expiry", 1'b1);
    write_csr(`CSR_TICLR, 32'h1, 32'h1);
    expect_int("timer interrupt cleared", 1'b0);
  endtask

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN));
    stop_on_error("Timeout: the tests did not finish within the expected time");
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    wr         = '0;
    rd_num     = '0;
    evt        = '0;
    hw_int     = '0;
    lfsr_state = LFSR_SEED;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_reset_values();
    test_masked_writes();
    test_exception_entry();
    test_exception_return();
    test_timer();
    test_interrupts();

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_exc_regs.sv
hdl/csr_int_ctrl.sv
hdl/csr_timer.sv
hdl/csr_save_regs.sv
hdl/csr_file.sv
sim/csr_file_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "No pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
